// ==== lbpSample.f ====
+incdir+src
src/lbpPkg.sv
src/rowBuffer.sv
src/windowGather.sv
src/bilinearSample.sv
src/lbpSampleTop.sv
sim/tb_lbpSample.sv

// ==== run.sh ====
#!/bin/sh
# build and run the lbpSample testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -j 0 \
  --top-module tb_lbpSample \
  -f lbpSample.f \
  -o simv

# the simulator exits non-zero on a fatal check, the log decides the result
./obj_dir/simv 2>&1 | tee "$LOG"

if grep -q "Testbench failed" "$LOG"; then
  echo "simulation FAILED, see $LOG"
  exit 1
fi

echo "simulation ok, see $LOG"

// ==== sim/tb_lbpSample.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lbp_config.svh"

module tb_lbpSample
  import lbpPkg::*;
;

  localparam int Period     = 40;
  localparam int Rows       = 6;
  // edges from accepting the completing pixel to sampleValid
  localparam int PipeEdges  = 4;
  // driven on one edge, accepted on the next, seen at the following negedge
  localparam int DueDelay   = (1 + PipeEdges) * Period + Period / 2;
  localparam int FullFrames = 5;
  localparam int CutRows    = 2;
  localparam int CutCols    = 7;
  localparam int NumFrames  = FullFrames + 1;
  localparam int TotalSamples = FullFrames * (Rows - 1) * (`IMG_WIDTH - 1)
                              + (CutRows - 1) * (`IMG_WIDTH - 1) + (CutCols - 1);
  localparam int TimeoutCycles = 4 * (NumFrames * `IMG_WIDTH * Rows) + 200;

  logic       clk;
  logic       rst_n;
  pixelBeat_t pixelIn;
  logic       pixelValid;
  sample_t    sample;
  logic       sampleValid;

  logic [31:0] rngState;
  pixel_t      frameMem [Rows][`IMG_WIDTH];
  int          mRow;
  int          mCol;
  sample_t     expQ [$];
  logic [63:0] dueQ [$];
  int          received;
  int          cycleCnt;

  lbpSampleTop dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .pixelIn     (pixelIn),
    .pixelValid  (pixelValid),
    .sample      (sample),
    .sampleValid (sampleValid)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(Period / 2) clk = ~clk;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [31:0] nextRandom(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // weighted sum with each product and pair sum cut to the result width
  function automatic sample_t refSample(input cornerSet_t c);
    weightSet_t  w;
    logic [31:0] pa;
    logic [31:0] pb;
    logic [31:0] pc;
    logic [31:0] pd;
    sample_t     ab;
    sample_t     cd;

    w  = weightsFor(`LBP_RADIUS, `LBP_ANGLE);
    pa = 32'(w.wa) * 32'(c.a);
    pb = 32'(w.wb) * 32'(c.b);
    pc = 32'(w.wc) * 32'(c.c);
    pd = 32'(w.wd) * 32'(c.d);
    ab = pa[`ACC_W-1:0] + pb[`ACC_W-1:0];
    cd = pc[`ACC_W-1:0] + pd[`ACC_W-1:0];
    return ab + cd;
  endfunction

  // all corners at 255 give 255 times the weight sum
  function automatic sample_t saturatedSample();
    weightSet_t  w;
    logic [31:0] wsum;
    logic [31:0] full;

    w    = weightsFor(`LBP_RADIUS, `LBP_ANGLE);
    wsum = 32'(w.wa) + 32'(w.wb) + 32'(w.wc) + 32'(w.wd);
    full = 32'd255 * wsum;
    return full[`ACC_W-1:0];
  endfunction

  task automatic checkEq(input logic [63:0] got, input logic [63:0] want, input string what);
    if (got !== want) begin
      $display("** Error at %0t ns: %s got 0x%0h, expected 0x%0h", $time, what, got, want);
      $display("Testbench failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic idleCycle(input pixel_t junk);
    @(posedge clk);
    pixelIn    <= '{sof: 1'b0, data: junk};
    pixelValid <= 1'b0;
  endtask

  // one beat plus the expected sample if it completes a window
  task automatic sendPixel(input pixel_t data, input logic sof);
    cornerSet_t c;
    sample_t    want;

    if (sof) begin
      mRow = 0;
      mCol = 0;
    end
    frameMem[mRow][mCol] = data;
    @(posedge clk);
    pixelIn    <= '{sof: sof, data: data};
    pixelValid <= 1'b1;
    if (mRow >= 1 && mCol >= 1) begin
      c.a  = frameMem[mRow-1][mCol-1];
      c.b  = frameMem[mRow-1][mCol];
      c.c  = frameMem[mRow][mCol-1];
      c.d  = data;
      want = refSample(c);
      if (c == '1) begin
        want = saturatedSample();
      end
      expQ.push_back(want);
      dueQ.push_back($time + 64'(DueDelay));
    end
    mCol++;
    if (mCol == `IMG_WIDTH) begin
      mCol = 0;
      mRow++;
    end
  endtask

  // first beat carries sof
  task automatic sendFrame(input int nPix, input logic withGaps, input logic saturated);
    pixel_t data;
    int     gap;

    for (int i = 0; i < nPix; i++) begin
      rngState = nextRandom(rngState);
      data     = saturated ? {`PIX_W{1'b1}} : rngState[7:0];
      if (withGaps && rngState[9:8] == 2'b00) begin
        gap = int'(rngState[11:10]) + 1;
        repeat (gap) idleCycle(rngState[19:12]);
      end
      sendPixel(data, i == 0);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // compare and timeout
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(negedge clk) begin
    if (rst_n && sampleValid) begin
      if (expQ.size() == 0) begin
        $display("Unexpected sample 0x%0h at %0t ns, no result was pending", sample, $time);
        $display("Testbench failed");
        $fatal(1, "unexpected output");
      end else begin
        checkEq(64'(sample), 64'(expQ.pop_front()), "sample value");
        checkEq($time, dueQ.pop_front(), "sampleValid time");
        received++;
      end
    end
  end

  always @(negedge clk) begin
    cycleCnt++;
    if (cycleCnt > TimeoutCycles) begin
      $display("Timeout after %0d cycles with %0d of %0d samples received",
               cycleCnt, received, TotalSamples);
      $display("Testbench failed");
      $fatal(1, "timeout");
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    rst_n      = 1'b0;
    pixelValid = 1'b0;
    pixelIn    = '0;
    rngState   = 32'hfa2c;
    mRow       = 0;
    mCol       = 0;
    received   = 0;
    cycleCnt   = 0;

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    checkEq(64'(sample), 64'd0, "sample after reset");
    checkEq(64'(sampleValid), 64'd0, "sampleValid after reset");

    // back to back and then with idle gaps
    sendFrame(Rows * `IMG_WIDTH, 1'b0, 1'b0);
    sendFrame(Rows * `IMG_WIDTH, 1'b1, 1'b0);
    sendFrame(Rows * `IMG_WIDTH, 1'b1, 1'b0);

    // frame cut short mid-row so the next sof restarts the counters
    sendFrame(CutRows * `IMG_WIDTH + CutCols, 1'b0, 1'b0);
    sendFrame(Rows * `IMG_WIDTH, 1'b1, 1'b0);

    sendFrame(Rows * `IMG_WIDTH, 1'b0, 1'b1);
    idleCycle('0);

    while (received < TotalSamples) begin
      @(negedge clk);
    end
    // room for stray extra samples
    repeat (2 * PipeEdges) @(negedge clk);

    if (expQ.size() == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      $display("%0d expected samples were never produced", expQ.size());
      $display("Testbench failed");
      $fatal(1, "missing samples");
    end
  end

endmodule

`default_nettype wire

// ==== src/bilinearSample.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lbp_config.svh"

module bilinearSample
  import lbpPkg::*;
#(
  parameter int Radius = `LBP_RADIUS,
  parameter int Angle  = `LBP_ANGLE
) (
  input  logic       clk,
  input  logic       rst_n,
  input  cornerSet_t corners,
  input  logic       cornersValid,
  output sample_t    sample,
  output logic       sampleValid
);

  weightSet_t weights;

  cornerSet_t cornersQ;
  logic       capValid;

  sample_t    prodA;
  sample_t    prodB;
  sample_t    prodC;
  sample_t    prodD;
  logic       prodValid;

  sample_t    sumAb;
  sample_t    sumCd;
  logic       pairValid;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // weights
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // loaded while in reset, held afterwards
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      weights <= weightsFor(Radius, Angle);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // multiply-add pipeline
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // stage 1, input capture
  always_ff @(posedge clk) begin
    if (cornersValid) begin
      cornersQ <= corners;
    end
  end

  // stage 2, products truncated to result width
  always_ff @(posedge clk) begin
    if (capValid) begin
      prodA <= weights.wa * cornersQ.a;
      prodB <= weights.wb * cornersQ.b;
      prodC <= weights.wc * cornersQ.c;
      prodD <= weights.wd * cornersQ.d;
    end
  end

  // stage 3, pair sums
  always_ff @(posedge clk) begin
    if (prodValid) begin
      sumAb <= prodA + prodB;
      sumCd <= prodC + prodD;
    end
  end

  // stage 4, final sum
  // output reads zero until the first result
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sample <= '0;
    end else if (pairValid) begin
      sample <= sumAb + sumCd;
    end
  end

  // valid travels with the data
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      capValid    <= 1'b0;
      prodValid   <= 1'b0;
      pairValid   <= 1'b0;
      sampleValid <= 1'b0;
    end else begin
      capValid    <= cornersValid;
      prodValid   <= capValid;
      pairValid   <= prodValid;
      sampleValid <= pairValid;
    end
  end

endmodule

`default_nettype wire

// ==== src/lbpPkg.sv ====
`default_nettype none
`include "lbp_config.svh"

package lbpPkg;

  // column index width
  localparam int ColW = $clog2(`IMG_WIDTH);

  typedef logic [`PIX_W-1:0] pixel_t;

  typedef struct packed {
    logic   sof;
    pixel_t data;
  } pixelBeat_t;

  // a b above, c d on the current row
  typedef struct packed {
    pixel_t a;
    pixel_t b;
    pixel_t c;
    pixel_t d;
  } cornerSet_t;

  // unsigned, 16 fraction bits
  typedef logic [`ACC_W-1:0] weight_t;

  typedef struct packed {
    weight_t wa;
    weight_t wb;
    weight_t wc;
    weight_t wd;
  } weightSet_t;

  typedef logic [`ACC_W-1:0] sample_t;

  // each radius has three distinct weights x y z
  // and the angle only permutes them over the corners
  function automatic weightSet_t weightsFor(input int radius, input int angle);
    weight_t    x;
    weight_t    y;
    weight_t    z;
    logic       known;
    weightSet_t w;

    known = 1'b1;
    x     = '0;
    y     = '0;
    z     = '0;
    w     = '0;
    case (radius)
      2: begin x = 24'h003E1D; y = 24'h0057D8; z = 24'h002BEC; end
      3: begin x = 24'h001B4A; y = 24'h00C5A6; z = 24'h0003C4; end
      4: begin x = 24'h002463; y = 24'h000789; z = 24'h00AFB0; end
      5: begin x = 24'h003FAD; y = 24'h003739; z = 24'h00496B; end
      6: begin x = 24'h002F0B; y = 24'h0092D6; z = 24'h000F12; end
      7: begin x = 24'h000C37; y = 24'h0000A5; z = 24'h00E6EA; end
      8: begin x = 24'h0039B3; y = 24'h001E24; z = 24'h006E73; end
      default: known = 1'b0;
    endcase

    if (known) begin
      case (angle)
        45:  w = '{wa: x, wb: y, wc: z, wd: x};
        135: w = '{wa: z, wb: x, wc: x, wd: y};
        225: w = '{wa: x, wb: z, wc: y, wd: x};
        315: w = '{wa: y, wb: x, wc: x, wd: z};
        default: w = '0;
      endcase
    end
    return w;
  endfunction

endpackage

`default_nettype wire

// ==== src/lbpSampleTop.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lbp_config.svh"

module lbpSampleTop
  import lbpPkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  pixelBeat_t pixelIn,
  input  logic       pixelValid,
  output sample_t    sample,
  output logic       sampleValid
);

  logic [ColW-1:0] column;
  pixel_t          pixelAbove;
  cornerSet_t      corners;
  logic            cornersValid;

  // pixel one row up, read before overwrite
  rowBuffer rowBuf0 (
    .clk    (clk),
    .rst_n  (rst_n),
    .wrData (pixelIn.data),
    .wrEn   (pixelValid),
    .column (column),
    .rdData (pixelAbove)
  );

  windowGather gather0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .pixelIn      (pixelIn),
    .pixelValid   (pixelValid),
    .pixelAbove   (pixelAbove),
    .column       (column),
    .corners      (corners),
    .cornersValid (cornersValid)
  );

  bilinearSample #(
    .Radius (`LBP_RADIUS),
    .Angle  (`LBP_ANGLE)
  ) interp0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .corners      (corners),
    .cornersValid (cornersValid),
    .sample       (sample),
    .sampleValid  (sampleValid)
  );

endmodule

`default_nettype wire

// ==== src/lbp_config.svh ====
`ifndef LBP_CONFIG_SVH
`define LBP_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// image geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// pixels per row, also the row buffer depth
`define IMG_WIDTH 16

// sampling point, radius 2 to 8 and a diagonal angle
`define LBP_RADIUS 3
`define LBP_ANGLE 45

// data widths
`define PIX_W 8
`define ACC_W 24

`endif

// ==== src/rowBuffer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lbp_config.svh"

module rowBuffer
  import lbpPkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  pixel_t          wrData,
  input  logic            wrEn,
  input  logic [ColW-1:0] column,
  output pixel_t          rdData
);

  // one entry per column of the image
  pixel_t lineMem [`IMG_WIDTH];

  // old content first, this is the pixel one row up
  assign rdData = lineMem[column];

  // no writes while reset is held
  always_ff @(posedge clk) begin
    if (rst_n && wrEn) begin
      lineMem[column] <= wrData;
    end
  end

endmodule

`default_nettype wire

// ==== src/windowGather.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lbp_config.svh"

module windowGather
  import lbpPkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  pixelBeat_t      pixelIn,
  input  logic            pixelValid,
  input  pixel_t          pixelAbove,
  output logic [ColW-1:0] column,
  output cornerSet_t      corners,
  output logic            cornersValid
);

  localparam int RowW = 16;
  localparam logic [ColW-1:0] LastCol = ColW'(`IMG_WIDTH - 1);

  logic [ColW-1:0] colCnt;
  logic [RowW-1:0] rowCnt;
  logic [RowW-1:0] curRow;
  logic [ColW-1:0] nextCol;
  logic [RowW-1:0] nextRow;
  logic            inFrame;
  pixel_t          prevPixel;
  pixel_t          prevAbove;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // raster position
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // sof beat sits at column 0, row 0
  assign column  = pixelIn.sof ? '0 : colCnt;
  assign curRow  = pixelIn.sof ? '0 : rowCnt;
  assign inFrame = (column != '0) && (curRow != '0);

  always_comb begin
    nextCol = column + 1'b1;
    nextRow = curRow;
    if (column == LastCol) begin
      nextCol = '0;
      // saturate, only row >= 1 matters
      if (curRow != '1) begin
        nextRow = curRow + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      colCnt <= '0;
      rowCnt <= '0;
    end else if (pixelValid) begin
      colCnt <= nextCol;
      rowCnt <= nextRow;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // corner set
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // left-hand corners of the next window
  always_ff @(posedge clk) begin
    if (pixelValid) begin
      prevPixel <= pixelIn.data;
      prevAbove <= pixelAbove;
    end
  end

  always_ff @(posedge clk) begin
    if (pixelValid) begin
      corners.a <= prevAbove;
      corners.b <= pixelAbove;
      corners.c <= prevPixel;
      corners.d <= pixelIn.data;
    end
  end

  // window needs a row above and a column to the left
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cornersValid <= 1'b0;
    end else begin
      cornersValid <= pixelValid && inFrame;
    end
  end

endmodule

`default_nettype wire
